// File: build.f
hw/mem_sys_pkg.sv
hw/cache_way_if.sv
hw/cache_way.sv
hw/banked_mem.sv
hw/cache_ctrl.sv
hw/mem_system.sv
verification/mem_system_tb.sv

// File: hw/banked_mem.sv
////////////////////////////////////////////////////////////
// Read data valid exactly MEM_LATENCY cycles after mem_rd
// Bank is address bits 2:1; no bank-busy check is made
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module banked_mem #(
   parameter int MEM_LATENCY = 2
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t mem_addr,
   input  mem_sys_pkg::word_t mem_wdata,
   input  logic               mem_wr,
   input  logic               mem_rd,
   output mem_sys_pkg::word_t mem_rdata
);
   import mem_sys_pkg::*;

   localparam int BANK_DEPTH = 8192;

   // Read pipeline, one stage per cycle of latency
   logic [MEM_LATENCY-1:0] rd_valid_q;
   offset_t                bank_q [MEM_LATENCY];
   logic [12:0]            row_q  [MEM_LATENCY];
   word_t                  bank_rdata [WORDS_PER_LINE];

   for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
      word_t words [BANK_DEPTH] = '{default: '0};

      always_ff @(posedge clk) begin
         if (mem_wr && (mem_addr[2:1] == offset_t'(b))) begin
            words[mem_addr[15:3]] <= mem_wdata;
         end
      end

      // Row of the read leaving the pipeline
      assign bank_rdata[b] = words[row_q[MEM_LATENCY-1]];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid_q <= '0;
      end else begin
         rd_valid_q[0] <= mem_rd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_valid_q[i] <= rd_valid_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      bank_q[0] <= mem_addr[2:1];
      row_q[0]  <= mem_addr[15:3];
      for (int i = 1; i < MEM_LATENCY; i++) begin
         bank_q[i] <= bank_q[i-1];
         row_q[i]  <= row_q[i-1];
      end
   end

   assign mem_rdata = rd_valid_q[MEM_LATENCY-1] ? bank_rdata[bank_q[MEM_LATENCY-1]] : '0;

   // One request per cycle from the controller
   a_rd_wr_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(mem_rd && mem_wr)
   );

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
////////////////////////////////////////////////////////////
// Requests are taken only while Stall is low
// A miss writes back a dirty victim, refills, then retries
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
   parameter int MEM_LATENCY = 2
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t Addr,
   input  mem_sys_pkg::word_t DataIn,
   input  logic               Rd,
   input  logic               Wr,
   output mem_sys_pkg::word_t DataOut,
   output logic               Done,
   output logic               Stall,
   output logic               CacheHit,
   output logic               err,
   cache_way_if.ctrl          way0,
   cache_way_if.ctrl          way1,
   output mem_sys_pkg::addr_t mem_addr,
   output mem_sys_pkg::word_t mem_wdata,
   output logic               mem_wr,
   output logic               mem_rd,
   input  mem_sys_pkg::word_t mem_rdata
);
   import mem_sys_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   // Latched request
   addr_t   req_addr;
   word_t   req_data;
   logic    req_wr;
   tag_t    req_tag;
   index_t  req_index;
   offset_t req_offset;
   logic    misaligned;

   logic [NUM_SETS-1:0]    lru;
   logic                   victim_way;
   logic                   victim_nxt;
   logic                   victim_dirty;
   tag_t                   victim_tag;
   offset_t                wb_cnt;
   logic [2:0]             rd_cnt;
   offset_t                ret_cnt;
   logic [MEM_LATENCY-1:0] rd_pipe;
   logic                   ret_valid;
   logic                   hit_any;
   logic                   access_done;

   // Shared way controls
   logic    way_en0;
   logic    way_en1;
   logic    way_comp;
   logic    way_write;
   offset_t way_offset;
   word_t   way_wdata;

   assign req_tag    = req_addr[15:11];
   assign req_index  = req_addr[10:3];
   assign req_offset = req_addr[2:1];
   assign misaligned = req_addr[0];
   assign hit_any    = way0.hit || way1.hit;
   // Mirrors the memory read pipeline
   assign ret_valid  = rd_pipe[MEM_LATENCY-1];

   // Invalid way first, else the one the LRU bit names
   always_comb begin
      if (!way0.valid) begin
         victim_nxt = 1'b0;
      end else if (!way1.valid) begin
         victim_nxt = 1'b1;
      end else begin
         victim_nxt = lru[req_index];
      end
   end

   assign victim_dirty = victim_nxt ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);
   assign victim_tag   = victim_way ? way1.tag_out : way0.tag_out;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (Rd || Wr) begin
               state_nxt = ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            if (misaligned || hit_any) begin
               state_nxt = ST_IDLE;
            end else if (victim_dirty) begin
               state_nxt = ST_WRITEBACK;
            end else begin
               state_nxt = ST_FILL;
            end
         end
         ST_WRITEBACK: begin
            if (wb_cnt == offset_t'(WORDS_PER_LINE - 1)) begin
               state_nxt = ST_FILL;
            end
         end
         ST_FILL: begin
            // Last refill word has come back
            if (ret_valid && (ret_cnt == offset_t'(WORDS_PER_LINE - 1))) begin
               state_nxt = ST_RETRY;
            end
         end
         ST_RETRY: state_nxt = ST_IDLE;
         default:  state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         victim_way <= 1'b0;
         wb_cnt     <= '0;
         rd_cnt     <= '0;
         ret_cnt    <= '0;
         rd_pipe    <= '0;
         lru        <= '0;
      end else begin
         state      <= state_nxt;
         rd_pipe[0] <= mem_rd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
         end
         if (state == ST_COMPARE) begin
            victim_way <= victim_nxt;
            wb_cnt     <= '0;
            rd_cnt     <= '0;
            ret_cnt    <= '0;
         end
         if (state == ST_WRITEBACK) begin
            wb_cnt <= wb_cnt + 1'b1;
         end
         // Issued and returned reads counted apart so they overlap
         if (mem_rd) begin
            rd_cnt <= rd_cnt + 1'b1;
         end
         if ((state == ST_FILL) && ret_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
         // Point LRU at the way not used
         if (access_done) begin
            lru[req_index] <= way0.hit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if ((state == ST_IDLE) && (Rd || Wr)) begin
         req_addr <= Addr;
         req_data <= DataIn;
         req_wr   <= Wr;
      end
   end

   always_comb begin
      way_en0    = 1'b0;
      way_en1    = 1'b0;
      way_comp   = 1'b0;
      way_write  = 1'b0;
      way_offset = req_offset;
      way_wdata  = req_data;
      case (state)
         ST_COMPARE, ST_RETRY: begin
            way_en0   = !misaligned;
            way_en1   = !misaligned;
            way_comp  = 1'b1;
            way_write = req_wr && !misaligned;
         end
         ST_WRITEBACK: begin
            way_en0    = !victim_way;
            way_en1    = victim_way;
            way_offset = wb_cnt;
         end
         ST_FILL: begin
            way_en0    = ret_valid && !victim_way;
            way_en1    = ret_valid && victim_way;
            way_write  = ret_valid;
            way_offset = ret_cnt;
            way_wdata  = mem_rdata;
         end
         default: ;
      endcase
   end

   assign way0.enable   = way_en0;
   assign way0.tag      = req_tag;
   assign way0.index    = req_index;
   assign way0.offset   = way_offset;
   assign way0.wdata    = way_wdata;
   assign way0.comp     = way_comp;
   assign way0.write    = way_write && way_en0;
   assign way0.valid_in = 1'b1;

   assign way1.enable   = way_en1;
   assign way1.tag      = req_tag;
   assign way1.index    = req_index;
   assign way1.offset   = way_offset;
   assign way1.wdata    = way_wdata;
   assign way1.comp     = way_comp;
   assign way1.write    = way_write && way_en1;
   assign way1.valid_in = 1'b1;

   // Memory side; write-back address comes from the victim's tag
   assign mem_wr    = (state == ST_WRITEBACK);
   assign mem_rd    = (state == ST_FILL) && (rd_cnt < WORDS_PER_LINE);
   assign mem_addr  = (state == ST_WRITEBACK) ? {victim_tag, req_index, wb_cnt, 1'b0}
                                              : {req_tag, req_index, rd_cnt[1:0], 1'b0};
   assign mem_wdata = victim_way ? way1.rdata : way0.rdata;

   // System side
   assign access_done = ((state == ST_COMPARE) && !misaligned && hit_any) ||
                        (state == ST_RETRY);
   assign DataOut  = way1.hit ? way1.rdata : way0.rdata;
   assign Done     = ((state == ST_COMPARE) && (misaligned || hit_any)) || (state == ST_RETRY);
   assign CacheHit = (state == ST_COMPARE) && !misaligned && hit_any;
   assign err      = (state == ST_COMPARE) && misaligned;
   assign Stall    = (state != ST_IDLE);

   // Done closes a request that was strobed or already stalling
   a_done_in_request: assert property (
      @(posedge clk) disable iff (!rst_n)
      Done |-> ($past(Stall) || $past(Rd || Wr)) ##1 !Stall
   );

endmodule

`default_nettype wire

// File: hw/cache_way.sv
////////////////////////////////////////////////////////////
// Lookup is combinational, writes land on the clock edge
// Compare-mode writes need a hit; access mode is for refill
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input  logic     clk,
   input  logic     rst_n,
   cache_way_if.way bus
);
   import mem_sys_pkg::*;

   // Per-set line storage
   tag_t                tag_mem  [NUM_SETS];
   word_t               data_mem [NUM_SETS][WORDS_PER_LINE];
   logic [NUM_SETS-1:0] valid_mem;
   logic [NUM_SETS-1:0] dirty_mem;

   logic line_hit;
   logic cmp_write;
   logic fill_write;

   // Lookup at the presented index
   assign line_hit    = valid_mem[bus.index] && (tag_mem[bus.index] == bus.tag);
   assign bus.hit     = line_hit;
   assign bus.valid   = valid_mem[bus.index];
   assign bus.dirty   = dirty_mem[bus.index];
   assign bus.tag_out = tag_mem[bus.index];
   assign bus.rdata   = data_mem[bus.index][bus.offset];

   // Store from the CPU side only into a matching line
   assign cmp_write  = bus.enable && bus.write && bus.comp && line_hit;
   // Refill overwrites the line whatever it held
   assign fill_write = bus.enable && bus.write && !bus.comp;

   // Status bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_mem <= '0;
         dirty_mem <= '0;
      end else begin
         if (cmp_write) begin
            dirty_mem[bus.index] <= 1'b1;
         end
         if (fill_write) begin
            valid_mem[bus.index] <= bus.valid_in;
            dirty_mem[bus.index] <= 1'b0;
         end
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (fill_write) begin
         tag_mem[bus.index] <= bus.tag;
      end
      if (cmp_write || fill_write) begin
         data_mem[bus.index][bus.offset] <= bus.wdata;
      end
   end

   // The controller only writes a way it has selected
   a_write_needs_enable: assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.write |-> bus.enable
   );

endmodule

`default_nettype wire

// File: hw/cache_way_if.sv
////////////////////////////////////////////////////////////
// One instance per way; way results are combinational
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface cache_way_if;
   import mem_sys_pkg::*;

   // Controller to way
   logic    enable;
   tag_t    tag;
   index_t  index;
   offset_t offset;
   word_t   wdata;
   logic    comp;
   logic    write;
   logic    valid_in;

   // Way to controller
   logic    hit;
   logic    dirty;
   logic    valid;
   tag_t    tag_out;
   word_t   rdata;

   modport ctrl (
      output enable, tag, index, offset, wdata, comp, write, valid_in,
      input  hit, dirty, valid, tag_out, rdata
   );

   modport way (
      input  enable, tag, index, offset, wdata, comp, write, valid_in,
      output hit, dirty, valid, tag_out, rdata
   );

endinterface

`default_nettype wire

// File: hw/mem_sys_pkg.sv
////////////////////////////////////////////////////////////
// Word accesses only; address bit 0 must be zero
////////////////////////////////////////////////////////////
`default_nettype none

package mem_sys_pkg;

   // Byte address and data word
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;

   // Address fields: tag 15:11, index 10:3, offset 2:1
   typedef logic [4:0] tag_t;
   typedef logic [7:0] index_t;
   typedef logic [1:0] offset_t;

   localparam int NUM_SETS       = 2 ** $bits(index_t);
   localparam int WORDS_PER_LINE = 4;

   // Cache controller states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WRITEBACK,
      ST_FILL,
      ST_RETRY
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/mem_system.sv
////////////////////////////////////////////////////////////
// Two-way write-back cache over four-bank memory
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
   parameter int MEM_LATENCY = 2
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t Addr,
   input  mem_sys_pkg::word_t DataIn,
   input  logic               Rd,
   input  logic               Wr,
   output mem_sys_pkg::word_t DataOut,
   output logic               Done,
   output logic               Stall,
   output logic               CacheHit,
   output logic               err
);
   import mem_sys_pkg::*;

   addr_t mem_addr;
   word_t mem_wdata;
   word_t mem_rdata;
   logic  mem_wr;
   logic  mem_rd;

   cache_way_if way0_bus ();
   cache_way_if way1_bus ();

   cache_way u_way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way0_bus.way)
   );

   cache_way u_way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way1_bus.way)
   );

   cache_ctrl #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .Addr      (Addr),
      .DataIn    (DataIn),
      .Rd        (Rd),
      .Wr        (Wr),
      .DataOut   (DataOut),
      .Done      (Done),
      .Stall     (Stall),
      .CacheHit  (CacheHit),
      .err       (err),
      .way0      (way0_bus.ctrl),
      .way1      (way1_bus.ctrl),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wr    (mem_wr),
      .mem_rd    (mem_rd),
      .mem_rdata (mem_rdata)
   );

   banked_mem #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wr    (mem_wr),
      .mem_rd    (mem_rd),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// File: verification/mem_system_tb.sv
////////////////////////////////////////////////////////////
// Requests are sent only while Stall is low, one at a time
// Outputs are sampled on the falling clock edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;
   import mem_sys_pkg::*;

   localparam int DONE_TIMEOUT = 50;
   localparam int RANDOM_REQS  = 400;

   logic  clk = 1'b0;
   logic  rst_n;
   addr_t Addr;
   word_t DataIn;
   logic  Rd;
   logic  Wr;
   word_t DataOut;
   logic  Done;
   logic  Stall;
   logic  CacheHit;
   logic  err;

   // Reference word memory plus a mirror of both ways
   word_t model_mem [32768];
   tag_t  m_tag     [2][NUM_SETS];
   logic  m_valid   [2][NUM_SETS];
   logic  m_lru     [NUM_SETS];

   logic [31:0] rng_state = 32'h1d9a;
   int          mismatch_count = 0;
   int          fail_count = 0;

   // Small address pool so that sets overflow often
   tag_t   tag_pool   [3] = '{5'h03, 5'h11, 5'h1c};
   index_t index_pool [4] = '{8'h05, 8'h3a, 8'h90, 8'hff};

   mem_system #(
      .MEM_LATENCY (2)
   ) u_mem_system (
      .clk      (clk),
      .rst_n    (rst_n),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   task automatic compare_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if ((mismatch_count == 0) && (fail_count == 0)) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   endtask

   // Victim is an invalid way first, way 0 before way 1, else the LRU way
   function automatic void model_access(input logic is_wr, input addr_t a, input word_t d,
                                        output word_t rdata, output logic hit);
      tag_t   t;
      index_t i;
      logic   way;
      t   = a[15:11];
      i   = a[10:3];
      hit = 1'b1;
      if (m_valid[0][i] && (m_tag[0][i] == t)) begin
         way = 1'b0;
      end else if (m_valid[1][i] && (m_tag[1][i] == t)) begin
         way = 1'b1;
      end else begin
         hit = 1'b0;
         if (!m_valid[0][i]) begin
            way = 1'b0;
         end else if (!m_valid[1][i]) begin
            way = 1'b1;
         end else begin
            way = m_lru[i];
         end
         m_valid[way][i] = 1'b1;
         m_tag[way][i]   = t;
      end
      m_lru[i] = !way;
      if (is_wr) begin
         model_mem[a[15:1]] = d;
      end
      rdata = model_mem[a[15:1]];
   endfunction

   // One strobe, then wait for Done while Stall stays high
   task automatic drive_request(input logic is_wr, input addr_t a, input word_t d,
                                output word_t rdata, output logic hit, output logic e);
      int   cycles;
      logic got_done;
      cycles   = 0;
      got_done = 1'b0;
      rdata    = '0;
      hit      = 1'b0;
      e        = 1'b0;
      @(posedge clk);
      Rd     <= !is_wr;
      Wr     <= is_wr;
      Addr   <= a;
      DataIn <= d;
      @(negedge clk);
      if (Stall !== 1'b0) begin
         $display("Stall was high in the strobe cycle for address %h", a);
         fail_count++;
      end
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;
      while (!got_done && (cycles < DONE_TIMEOUT)) begin
         @(negedge clk);
         if (Stall !== 1'b1) begin
            $display("Stall was low during the request to address %h", a);
            fail_count++;
         end
         if (Done === 1'b1) begin
            got_done = 1'b1;
            rdata    = DataOut;
            hit      = CacheHit;
            e        = err;
         end
         cycles++;
      end
      if (!got_done) begin
         $display("Done never came for the request to address %h", a);
         fail_count++;
         finish_run();
      end else begin
         @(negedge clk);
         if (Stall !== 1'b0) begin
            $display("Stall stayed high after Done for address %h", a);
            fail_count++;
         end
      end
   endtask

   task automatic run_access(input string name, input logic is_wr, input addr_t a,
                             input word_t d);
      word_t exp_data;
      logic  exp_hit;
      word_t got_data;
      logic  got_hit;
      logic  got_err;
      model_access(is_wr, a, d, exp_data, exp_hit);
      drive_request(is_wr, a, d, got_data, got_hit, got_err);
      compare_bit({name, " err"}, 1'b0, got_err);
      compare_bit({name, " hit"}, exp_hit, got_hit);
      if (!is_wr) begin
         compare_word({name, " data"}, exp_data, got_data);
      end
   endtask

   // Misaligned requests leave the model untouched
   task automatic run_misaligned(input string name, input logic is_wr, input addr_t a,
                                 input word_t d);
      word_t got_data;
      logic  got_hit;
      logic  got_err;
      drive_request(is_wr, a, d, got_data, got_hit, got_err);
      compare_bit({name, " err"}, 1'b1, got_err);
      compare_bit({name, " hit"}, 1'b0, got_hit);
   endtask

   initial begin : main
      logic [31:0] r;
      logic [31:0] r_data;
      addr_t       a;
      word_t       d;
      rst_n  = 1'b0;
      Rd     = 1'b0;
      Wr     = 1'b0;
      Addr   = '0;
      DataIn = '0;
      for (int i = 0; i < 32768; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < NUM_SETS; i++) begin
         m_valid[0][i] = 1'b0;
         m_valid[1][i] = 1'b0;
         m_tag[0][i]   = '0;
         m_tag[1][i]   = '0;
         m_lru[i]      = 1'b0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare_bit("reset stall", 1'b0, Stall);
      compare_bit("reset done", 1'b0, Done);
      compare_bit("reset hit", 1'b0, CacheHit);
      compare_bit("reset err", 1'b0, err);

      // Cold read, then the same word again
      run_access("cold read", 1'b0, 16'h0128, '0);
      run_access("re-read", 1'b0, 16'h0128, '0);
      // Write then read back
      run_access("write", 1'b1, 16'h4a36, 16'hbeef);
      run_access("read after write", 1'b0, 16'h4a36, '0);
      // Three tags in set 0x21 push out a dirty line
      run_access("evict write a", 1'b1, {5'h02, 8'h21, 2'd1, 1'b0}, 16'h1111);
      run_access("evict write b", 1'b1, {5'h09, 8'h21, 2'd2, 1'b0}, 16'h2222);
      run_access("evict write c", 1'b1, {5'h17, 8'h21, 2'd3, 1'b0}, 16'h3333);
      run_access("evict read a", 1'b0, {5'h02, 8'h21, 2'd1, 1'b0}, '0);
      run_access("evict read b", 1'b0, {5'h09, 8'h21, 2'd2, 1'b0}, '0);
      // Odd address must not disturb the stored word
      run_misaligned("misaligned write", 1'b1, 16'h4a37, 16'hdead);
      run_access("read after misaligned", 1'b0, 16'h4a36, '0);

      for (int n = 0; n < RANDOM_REQS; n++) begin
         r      = next_rand();
         a      = {tag_pool[r[31:24] % 3], index_pool[r[18:17]], r[20:19], 1'b0};
         r_data = next_rand();
         d      = r_data[31:16];
         if (r[23:21] == 3'd0) begin
            run_misaligned("random misaligned", r[16], a | 16'h0001, d);
         end else begin
            run_access("random", r[16], a, d);
         end
      end

      finish_run();
   end

endmodule

`default_nettype wire
